// File: flist.f
+incdir+verilog
verilog/wbc_pkg.sv
verilog/rr_arbiter.sv
verilog/reorder_buffer.sv
verilog/writeback_commit.sv
verilog/arch_regfile.sv
verilog/wbc_top.sv
verif/wbc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the writeback and commit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module wbc_tb \
  -f flist.f \
  -o wbc_sim

./obj_dir/wbc_sim > sim.log 2>&1
cat sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verif/wbc_tb.sv
//--------------------------------------------------------------------------
// Writeback and commit testbench
// Random out-of-order issue on the execute pipes, a scoreboard by sequence
// number and concurrent assertions on grant, completion, commit and reads
//--------------------------------------------------------------------------

`include "wbc_settings.svh"

module wbc_tb import wbc_pkg::*; ();

  localparam int num_pipes  = `WBC_NUM_PIPES;
  localparam int seq_bits   = `WBC_SEQ_BITS;
  localparam int depth      = 2 ** seq_bits;
  localparam int reg_bits   = $clog2(`WBC_NUM_REGS);
  localparam int num_insts  = 300;
  localparam int burst_len  = 40;  // Issues with no gaps, both pipes busy
  localparam int rst_cycles = 16;

  logic                     clk;
  logic                     rst;
  logic [num_pipes-1:0]     x_val;
  x_w_msg_t [num_pipes-1:0] x_msg;
  logic [num_pipes-1:0]     x_rdy;
  complete_msg_t            complete_msg;
  commit_msg_t              commit_msg;
  logic [reg_bits-1:0]      rs1_addr;
  logic [reg_bits-1:0]      rs2_addr;
  logic [31:0]              rs1_data;
  logic [31:0]              rs2_data;

  wbc_top uut (
    .clk          (clk),
    .rst          (rst),
    .x_val        (x_val),
    .x_msg        (x_msg),
    .x_rdy        (x_rdy),
    .complete_msg (complete_msg),
    .commit_msg   (commit_msg),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //------------------------------------------------------------------------
  // Scoreboard and reference register file
  //------------------------------------------------------------------------

  rob_entry_t          sb [depth];      // Recorded at acceptance
  logic [depth-1:0]    sb_live;         // Accepted, not yet committed
  logic [seq_bits-1:0] exp_seq;         // Next sequence number to commit
  logic [31:0]         ref_regs [`WBC_NUM_REGS];
  logic [num_pipes-1:0] acc_q;          // Handshakes of the last edge
  logic [reg_bits-1:0] last_waddr;      // Target of the latest commit
  int                  commit_count;

  always @(posedge clk) begin
    if (rst) begin
      sb_live      <= '0;
      exp_seq      <= '0;
      acc_q        <= '0;
      last_waddr   <= '0;
      commit_count <= 0;
      for (int r = 0; r < `WBC_NUM_REGS; r++) begin
        ref_regs[r] <= '0;
      end
    end else begin
      acc_q <= x_val & x_rdy;
      for (int i = 0; i < num_pipes; i++) begin
        if (x_val[i] && x_rdy[i]) begin
          sb[x_msg[i].seq_num].pc    <= x_msg[i].pc;
          sb[x_msg[i].seq_num].waddr <= x_msg[i].waddr;
          sb[x_msg[i].seq_num].wdata <= x_msg[i].wdata;
          sb[x_msg[i].seq_num].wen   <= x_msg[i].wen && (x_msg[i].waddr != '0);
          sb_live[x_msg[i].seq_num]  <= 1'b1;
        end
      end
      if (commit_msg.val) begin
        sb_live[exp_seq] <= 1'b0;
        exp_seq          <= exp_seq + 1'b1;  // Wraps at depth
        commit_count     <= commit_count + 1;
        last_waddr       <= sb[exp_seq].waddr;
        if (sb[exp_seq].wen) begin
          ref_regs[sb[exp_seq].waddr] <= sb[exp_seq].wdata;
        end
      end
    end
  end

  complete_msg_t exp_cmp;   // From the accepted pipe
  commit_msg_t   exp_cmt;   // From the scoreboard at the expected head
  logic          cmt_live;
  logic [31:0]   exp_rs1;
  logic [31:0]   exp_rs2;

  always_comb begin
    exp_cmp = '0;
    for (int i = 0; i < num_pipes; i++) begin
      if (x_val[i] && x_rdy[i]) begin
        exp_cmp.val     = 1'b1;
        exp_cmp.seq_num = x_msg[i].seq_num;
        exp_cmp.waddr   = x_msg[i].waddr;
        exp_cmp.wdata   = x_msg[i].wdata;
        exp_cmp.wen     = x_msg[i].wen && (x_msg[i].waddr != '0);  // x0 never written
      end
    end
  end

  always_comb begin
    exp_cmt.val     = 1'b1;
    exp_cmt.seq_num = exp_seq;
    exp_cmt.pc      = sb[exp_seq].pc;
    exp_cmt.waddr   = sb[exp_seq].waddr;
    exp_cmt.wdata   = sb[exp_seq].wdata;
    exp_cmt.wen     = sb[exp_seq].wen;
  end

  assign cmt_live = sb_live[exp_seq];
  assign exp_rs1  = ref_regs[rs1_addr];
  assign exp_rs2  = ref_regs[rs2_addr];

  //------------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------------

  int err_rst = 0;
  int err_arb = 0;
  int err_cmp = 0;
  int err_cmt = 0;
  int err_rf  = 0;

  reset_idle: assert property (@(posedge clk) $fell(rst) |->
    (x_rdy == '0 && !complete_msg.val && !commit_msg.val && rs1_data == '0 && rs2_data == '0))
    else begin
      err_rst++;
      $display("Error: after reset x_rdy=%h complete_msg.val=%h commit_msg.val=%h",
               $sampled(x_rdy), $sampled(complete_msg.val), $sampled(commit_msg.val));
      $display("Error: after reset rs1_data=%h rs2_data=%h",
               $sampled(rs1_data), $sampled(rs2_data));
    end

  grant_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(x_rdy) && ((x_rdy & ~x_val) == '0) && (x_val == '0 || x_rdy != '0))
    else begin
      err_arb++;
      $display("Error: x_rdy=%h with x_val=%h", $sampled(x_rdy), $sampled(x_val));
    end

  // Both pipes waiting back to back, the winner must change
  grant_rotates: assert property (@(posedge clk) disable iff (rst)
    (&x_val && $past(&x_val) && !$past(rst)) |-> x_rdy != $past(x_rdy))
    else begin
      err_arb++;
      $display("Error: x_rdy=%h repeated from the last cycle", $sampled(x_rdy));
    end

  complete_match: assert property (@(posedge clk) disable iff (rst)
    complete_msg.val == exp_cmp.val && (!exp_cmp.val || complete_msg == exp_cmp))
    else begin
      err_cmp++;
      $display("Error: complete_msg got %h expected %h",
               $sampled(complete_msg), $sampled(exp_cmp));
    end

  commit_once: assert property (@(posedge clk) disable iff (rst)
    commit_msg.val |-> cmt_live)
    else begin
      err_cmt++;
      $display("Error: commit of seq_num %h with no accepted instruction waiting for it",
               $sampled(commit_msg.seq_num));
    end

  commit_match: assert property (@(posedge clk) disable iff (rst)
    commit_msg.val |-> commit_msg == exp_cmt)
    else begin
      err_cmt++;
      $display("Error: commit_msg got %h expected %h",
               $sampled(commit_msg), $sampled(exp_cmt));
    end

  read_match: assert property (@(posedge clk) disable iff (rst)
    rs1_data == exp_rs1 && rs2_data == exp_rs2)
    else begin
      err_rf++;
      $display("Error: rs1_data got %h expected %h at rs1_addr %h",
               $sampled(rs1_data), $sampled(exp_rs1), $sampled(rs1_addr));
      $display("Error: rs2_data got %h expected %h at rs2_addr %h",
               $sampled(rs2_data), $sampled(exp_rs2), $sampled(rs2_addr));
    end

  read_x0: assert property (@(posedge clk)
    (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0))
    else begin
      err_rf++;
      $display("Error: x0 read rs1_data=%h rs2_data=%h", $sampled(rs1_data), $sampled(rs2_data));
    end

  //------------------------------------------------------------------------
  // Stimulus, driven on the falling edge
  //------------------------------------------------------------------------

  logic [num_pipes-1:0] busy;            // Pipe holds an unaccepted message
  int                   delay [num_pipes];
  logic [seq_bits-1:0]  next_seq;
  int                   issued;

  task automatic drive_pipes();
    logic start;
    for (int i = 0; i < num_pipes; i++) begin
      if (acc_q[i]) begin
        x_val[i] = 1'b0;
        busy[i]  = 1'b0;
      end
      start = !busy[i] && issued < num_insts && (issued - commit_count) < depth - 1;
      if (start && (issued < burst_len || $urandom % 3 != 0)) begin
        x_msg[i].pc      = $urandom;
        x_msg[i].seq_num = next_seq;
        x_msg[i].waddr   = ($urandom % 6 == 0) ? '0 : reg_bits'($urandom);
        x_msg[i].wdata   = $urandom;
        x_msg[i].wen     = ($urandom % 4 != 0);
        delay[i] = (issued < burst_len || $urandom % 3 != 0) ? 0 : 1 + int'($urandom % 6);
        next_seq = next_seq + 1'b1;
        issued   = issued + 1;
        busy[i]  = 1'b1;
      end
      if (busy[i] && !x_val[i]) begin  // Held back pipes let younger ones pass
        if (delay[i] == 0) begin
          x_val[i] = 1'b1;
        end else begin
          delay[i] = delay[i] - 1;
        end
      end
    end
  endtask

  task automatic drive_reads();
    rs1_addr = ($urandom % 2 == 0) ? last_waddr : reg_bits'($urandom);
    rs2_addr = ($urandom % 4 == 0) ? '0 : reg_bits'($urandom);
  endtask

  task automatic report_counts();
    $display("Errors: reset %0d, arbitration %0d, completion %0d, commit %0d, regfile %0d",
             err_rst, err_arb, err_cmp, err_cmt, err_rf);
  endtask

  initial begin
    void'($urandom(23));
    rst      = 1'b1;
    x_val    = '0;
    x_msg    = '0;
    rs1_addr = reg_bits'(5);
    rs2_addr = reg_bits'(9);
    busy     = '0;
    next_seq = '0;
    issued   = 0;
    for (int i = 0; i < num_pipes; i++) begin
      delay[i] = 0;
    end
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (commit_count < num_insts) begin
      @(negedge clk);
      drive_pipes();
      drive_reads();
    end
    x_val = '0;
    repeat (8) @(negedge clk);  // Idle tail, catches stray commits
    report_counts();
    if (err_rst + err_arb + err_cmp + err_cmt + err_rf == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (rst_cycles + num_insts * 20) @(posedge clk);
    $display("Timeout: %0d of %0d instructions committed", commit_count, num_insts);
    report_counts();
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: verilog/wbc_top.sv
//--------------------------------------------------------------------------
// Writeback and commit top level
// Writeback unit feeding the architectural register file
//--------------------------------------------------------------------------

`include "wbc_settings.svh"

module wbc_top import wbc_pkg::*; (
  input  logic                             clk,
  input  logic                             rst,

  // Execute pipes
  input  logic [`WBC_NUM_PIPES-1:0]        x_val,
  input  x_w_msg_t [`WBC_NUM_PIPES-1:0]    x_msg,
  output logic [`WBC_NUM_PIPES-1:0]        x_rdy,

  // Notices to the rest of the core
  output complete_msg_t                    complete_msg,
  output commit_msg_t                      commit_msg,

  // Decode read ports
  input  logic [$clog2(`WBC_NUM_REGS)-1:0] rs1_addr,
  input  logic [$clog2(`WBC_NUM_REGS)-1:0] rs2_addr,
  output logic [31:0]                      rs1_data,
  output logic [31:0]                      rs2_data
);

  writeback_commit wbc (
    .clk          (clk),
    .rst          (rst),
    .x_val        (x_val),
    .x_msg        (x_msg),
    .x_rdy        (x_rdy),
    .complete_msg (complete_msg),
    .commit_msg   (commit_msg)
  );

  arch_regfile regfile (
    .clk        (clk),
    .rst        (rst),
    .commit_msg (commit_msg),  // Same notice seen by the outside
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data)
  );

endmodule

// File: verilog/arch_regfile.sv
//--------------------------------------------------------------------------
// Architectural register file
// Written on commit, two combinational read ports for decode
//--------------------------------------------------------------------------

`include "wbc_settings.svh"

module arch_regfile import wbc_pkg::*; (
  input  logic                             clk,
  input  logic                             rst,
  input  commit_msg_t                      commit_msg,
  input  logic [$clog2(`WBC_NUM_REGS)-1:0] rs1_addr,
  input  logic [$clog2(`WBC_NUM_REGS)-1:0] rs2_addr,
  output logic [31:0]                      rs1_data,
  output logic [31:0]                      rs2_data
);

  logic [31:0] regs [`WBC_NUM_REGS];

  //------------------------------------------------------------------------
  // Commit write port
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < `WBC_NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (commit_msg.val && commit_msg.wen) begin
      regs[commit_msg.waddr] <= commit_msg.wdata;
    end
  end

  //------------------------------------------------------------------------
  // Read ports
  //------------------------------------------------------------------------

  // x0 is hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? 32'd0 : regs[rs2_addr];

  // Writes to x0 are dropped upstream in the writeback unit
  no_x0_commit: assert property (@(posedge clk) disable iff (rst)
    commit_msg.val && commit_msg.wen |-> commit_msg.waddr != '0);

endmodule

// File: verilog/writeback_commit.sv
//--------------------------------------------------------------------------
// Writeback and commit unit
// Picks one execute pipe per cycle, broadcasts completion, reorders
// results by sequence number and commits them in order
//--------------------------------------------------------------------------

`include "wbc_settings.svh"

module writeback_commit import wbc_pkg::*; (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`WBC_NUM_PIPES-1:0]           x_val,
  input  x_w_msg_t [`WBC_NUM_PIPES-1:0]       x_msg,
  output logic [`WBC_NUM_PIPES-1:0]           x_rdy,
  output complete_msg_t                       complete_msg,
  output commit_msg_t                         commit_msg
);

  logic [`WBC_NUM_PIPES-1:0] gnt;
  x_w_msg_t                  sel_raw;  // OR of the grant-masked pipe messages
  x_w_msg_t                  sel_msg;  // Same with wen fixed for register zero
  logic                      sel_val;

  //------------------------------------------------------------------------
  // Pipe selection
  //------------------------------------------------------------------------

  rr_arbiter #(
    .num_req (`WBC_NUM_PIPES)
  ) pipe_arb (
    .clk (clk),
    .rst (rst),
    .req (x_val),
    .gnt (gnt)
  );

  assign x_rdy   = gnt;   // No back-pressure besides losing arbitration
  assign sel_val = |gnt;  // Grant only goes to a valid pipe

  always_comb begin
    sel_raw = '0;
    for (int i = 0; i < `WBC_NUM_PIPES; i++) begin
      sel_raw = sel_raw | (x_msg[i] & {$bits(x_w_msg_t){gnt[i]}});
    end
  end

  // Register zero is never written
  always_comb begin
    sel_msg     = sel_raw;
    sel_msg.wen = sel_raw.wen && (sel_raw.waddr != '0);
  end

  //------------------------------------------------------------------------
  // Completion broadcast, same cycle as the grant
  //------------------------------------------------------------------------

  always_comb begin
    complete_msg.val     = sel_val;
    complete_msg.seq_num = sel_msg.seq_num;
    complete_msg.waddr   = sel_msg.waddr;
    complete_msg.wdata   = sel_msg.wdata;
    complete_msg.wen     = sel_msg.wen;
  end

  //------------------------------------------------------------------------
  // Input register
  //------------------------------------------------------------------------

  logic       in_val;
  x_w_msg_t   in_msg;
  rob_entry_t ins_entry;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_val <= 1'b0;
    end else begin
      in_val <= sel_val;
    end
  end

  always_ff @(posedge clk) begin
    in_msg <= sel_msg;
  end

  always_comb begin
    ins_entry.pc    = in_msg.pc;
    ins_entry.waddr = in_msg.waddr;
    ins_entry.wdata = in_msg.wdata;
    ins_entry.wen   = in_msg.wen;  // Already cleared for register zero
  end

  //------------------------------------------------------------------------
  // Reorder buffer
  //------------------------------------------------------------------------

  reorder_buffer #(
    .seq_bits (`WBC_SEQ_BITS)
  ) rob (
    .clk        (clk),
    .rst        (rst),
    .ins_en     (in_val),
    .ins_idx    (in_msg.seq_num),
    .ins_entry  (ins_entry),
    .commit_msg (commit_msg)
  );

  // Every completion comes from an accepted pipe
  complete_granted: assert property (@(posedge clk) disable iff (rst)
    complete_msg.val |-> ((x_rdy & x_val) != '0));

endmodule

// File: verilog/reorder_buffer.sv
//--------------------------------------------------------------------------
// Reorder buffer
// Results land at their sequence number, leave strictly in order
//--------------------------------------------------------------------------

`include "wbc_settings.svh"

module reorder_buffer import wbc_pkg::*; #(
  parameter int seq_bits = `WBC_SEQ_BITS
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ins_en,
  input  logic [seq_bits-1:0] ins_idx,
  input  rob_entry_t          ins_entry,
  output commit_msg_t         commit_msg
);

  localparam int depth = 2 ** seq_bits;

  logic [depth-1:0]    valid;          // Entry holds a finished result
  rob_entry_t          entries [depth];
  logic [seq_bits-1:0] head;           // Oldest uncommitted sequence number
  logic                deq;

  assign deq = valid[head];  // Commit is never stalled

  //------------------------------------------------------------------------
  // Control state
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      head  <= '0;
    end else begin
      if (deq) begin
        valid[head] <= 1'b0;
        head        <= head + 1'b1;  // Wraps at depth
      end
      if (ins_en) begin
        valid[ins_idx] <= 1'b1;
      end
    end
  end

  //------------------------------------------------------------------------
  // Payload storage
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ins_en) begin
      entries[ins_idx] <= ins_entry;
    end
  end

  //------------------------------------------------------------------------
  // Head entry out as the commit notice
  //------------------------------------------------------------------------

  always_comb begin
    commit_msg.val     = deq;
    commit_msg.seq_num = head;
    commit_msg.pc      = entries[head].pc;
    commit_msg.waddr   = entries[head].waddr;
    commit_msg.wdata   = entries[head].wdata;
    commit_msg.wen     = entries[head].wen;
  end

  // A sequence number still in flight must not be reused upstream
  no_overwrite: assert property (@(posedge clk) disable iff (rst)
    ins_en |-> !valid[ins_idx]);

endmodule

// File: verilog/rr_arbiter.sv
//--------------------------------------------------------------------------
// Round-robin arbiter
// One-hot grant, priority rotates to just past the last winner
//--------------------------------------------------------------------------

module rr_arbiter #(
  parameter int num_req = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [num_req-1:0] req,
  output logic [num_req-1:0] gnt
);

  localparam int ptr_bits = (num_req > 1) ? $clog2(num_req) : 1;

  logic [ptr_bits-1:0] ptr;      // Highest priority requester
  logic [ptr_bits-1:0] win_idx;  // Requester granted this cycle

  // Scan from the pointer, wrapping around
  always_comb begin
    int   idx;
    logic found;
    gnt     = '0;
    win_idx = ptr;
    found   = 1'b0;
    for (int off = 0; off < num_req; off++) begin
      idx = (int'(ptr) + off) % num_req;
      if (!found && req[idx]) begin
        gnt[idx] = 1'b1;
        win_idx  = ptr_bits'(idx);
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (|gnt) begin
      ptr <= ptr_bits'((int'(win_idx) + 1) % num_req);  // Winner drops to last
    end
  end

  // Grant is one-hot or idle and never goes to an idle requester
  gnt_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

// File: verilog/wbc_pkg.sv
//--------------------------------------------------------------------------
// Writeback and commit types
// Execute result, completion, commit and reorder buffer entry formats
//--------------------------------------------------------------------------

`include "wbc_settings.svh"

package wbc_pkg;

  // One finished instruction from an execute pipe
  typedef struct packed {
    logic [31:0]                     pc;
    logic [`WBC_SEQ_BITS-1:0]        seq_num;
    logic [$clog2(`WBC_NUM_REGS)-1:0] waddr;
    logic [31:0]                     wdata;
    logic                            wen;
  } x_w_msg_t;

  // Completion notice, for wakeup and bypass
  typedef struct packed {
    logic                            val;
    logic [`WBC_SEQ_BITS-1:0]        seq_num;
    logic [$clog2(`WBC_NUM_REGS)-1:0] waddr;
    logic [31:0]                     wdata;
    logic                            wen;
  } complete_msg_t;

  // In-order commit notice
  typedef struct packed {
    logic                            val;
    logic [`WBC_SEQ_BITS-1:0]        seq_num;
    logic [31:0]                     pc;
    logic [$clog2(`WBC_NUM_REGS)-1:0] waddr;
    logic [31:0]                     wdata;
    logic                            wen;
  } commit_msg_t;

  // Reorder buffer payload, index is the sequence number
  typedef struct packed {
    logic [31:0]                     pc;
    logic [$clog2(`WBC_NUM_REGS)-1:0] waddr;
    logic [31:0]                     wdata;
    logic                            wen;
  } rob_entry_t;

endpackage

// File: verilog/wbc_settings.svh
//--------------------------------------------------------------------------
// Writeback and commit settings
// Pipe count, sequence number width and register count
//--------------------------------------------------------------------------

`ifndef WBC_SETTINGS_SVH
`define WBC_SETTINGS_SVH

// Execute pipes feeding the writeback arbiter
`define WBC_NUM_PIPES 2

// Sequence number width, the reorder buffer holds 2**WBC_SEQ_BITS entries
`define WBC_SEQ_BITS 3

// Architectural integer registers
`define WBC_NUM_REGS 32

`endif
